// File: hdl/vram_pkg.sv
// Video memory package with bus widths, address map, LED timing and APB slave states
package vram_pkg;

    // Bus side
    typedef logic [15:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Memory geometry
    localparam int VRAM32_WORDS     = 1056;
    localparam int VRAM8_WORDS      = 8192;
    localparam int VRAM32_ADDR_BITS = $clog2(VRAM32_WORDS);
    localparam int VRAM8_ADDR_BITS  = $clog2(VRAM8_WORDS);

    typedef logic [VRAM32_ADDR_BITS-1:0] vram32_addr_t;
    typedef logic [VRAM8_ADDR_BITS-1:0]  vram8_addr_t;
    typedef logic [31:0]                 vram32_word_t;
    typedef logic [7:0]                  vram8_word_t;

    // Word address map, limits are exclusive
    localparam apb_addr_t VRAM32_BASE  = 16'h0000;
    localparam apb_addr_t VRAM32_LIMIT = 16'h0420;
    localparam apb_addr_t VRAM8_BASE   = 16'h2000;
    localparam apb_addr_t VRAM8_LIMIT  = 16'h4000;

    // GPU activity LED on-time
    localparam int LED_MIN_CLK  = 16;
    localparam int LED_CNT_BITS = $clog2(LED_MIN_CLK + 1);

    typedef logic [LED_CNT_BITS-1:0] led_cnt_t;

    // APB slave phases
    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_read_wait
    } apb_state_t;

endpackage

// File: hdl/vram_dp.sv
// Dual-port video memory with a CPU read/write port and a GPU read-only port
`timescale 1ns/1ps

module vram_dp #(
    parameter int WIDTH = 32,
    parameter int WORDS = 1056
) (
    input  logic                     clk,

    // CPU port
    input  logic [$clog2(WORDS)-1:0] cpu_addr,
    input  logic [WIDTH-1:0]         cpu_d,
    input  logic                     cpu_we,
    output logic [WIDTH-1:0]         cpu_q,

    // GPU port
    input  logic [$clog2(WORDS)-1:0] gpu_addr,
    output logic [WIDTH-1:0]         gpu_q
);

    logic [WIDTH-1:0] mem [WORDS];

    // CPU side, q shows the old contents on a write
    always_ff @(posedge clk) begin
        cpu_q <= mem[cpu_addr];
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_d;
        end
    end

    // GPU side, one read per cycle
    always_ff @(posedge clk) begin
        gpu_q <= mem[gpu_addr];
    end

endmodule

// File: hdl/led_visualizer.sv
// Activity LED timer that stretches short write pulses into a visible on-time
`timescale 1ns/1ps

module led_visualizer (
    input  logic clk,
    input  logic reset,
    input  logic write_strobe,
    output logic led
);

    import vram_pkg::*;

    led_cnt_t cnt;

    // Each strobe restarts the full on-time
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (write_strobe) begin
            cnt <= led_cnt_t'(LED_MIN_CLK);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Lit for LED_MIN_CLK cycles after the last strobe
    assign led = (cnt != '0);

endmodule

// File: hdl/apb_vram_fsm.sv
// APB slave that decodes the video memory map and drives the CPU ports of both memories
`timescale 1ns/1ps

module apb_vram_fsm (
    input  logic                   clk,
    input  logic                   reset,

    // APB
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  vram_pkg::apb_addr_t    paddr,
    input  vram_pkg::apb_data_t    pwdata,
    output logic                   pready,
    output logic                   pslverr,
    output vram_pkg::apb_data_t    prdata,

    // 32-bit memory CPU port
    output vram_pkg::vram32_addr_t vram32_addr,
    output vram_pkg::vram32_word_t vram32_d,
    output logic                   vram32_we,
    input  vram_pkg::vram32_word_t vram32_q,

    // 8-bit memory CPU port
    output vram_pkg::vram8_addr_t  vram8_addr,
    output vram_pkg::vram8_word_t  vram8_d,
    output logic                   vram8_we,
    input  vram_pkg::vram8_word_t  vram8_q,

    // Activity pulse for the GPU LED
    output logic                   write_strobe
);

    import vram_pkg::*;

    apb_state_t state;
    apb_state_t next_state;

    logic       access;
    logic       in32;
    logic       in8;
    logic       in_range;
    logic       rd_hit;
    apb_addr_t  vram32_off;
    apb_addr_t  vram8_off;

    // Address decode, paddr is stable for the whole transfer
    assign in32     = (paddr >= VRAM32_BASE) && (paddr < VRAM32_LIMIT);
    assign in8      = (paddr >= VRAM8_BASE) && (paddr < VRAM8_LIMIT);
    assign in_range = in32 || in8;

    assign vram32_off  = paddr - VRAM32_BASE;
    assign vram8_off   = paddr - VRAM8_BASE;
    assign vram32_addr = vram32_off[VRAM32_ADDR_BITS-1:0];
    assign vram8_addr  = vram8_off[VRAM8_ADDR_BITS-1:0];

    // Only the low byte goes to the character memory
    assign vram32_d = pwdata;
    assign vram8_d  = pwdata[7:0];

    // First access cycle of a transfer
    assign access = (state == st_access) && psel && penable;

    // In-range read needs one wait state for the registered memory output
    assign rd_hit = access && !pwrite && in_range;

    assign vram32_we    = access && pwrite && in32;
    assign vram8_we     = access && pwrite && in8;
    assign write_strobe = vram32_we || vram8_we;

    assign pready  = (access && !rd_hit) || (state == st_read_wait);
    assign pslverr = access && !in_range;

    // Read data only in the completing cycle of an in-range read
    always_comb begin
        prdata = '0;
        if (state == st_read_wait) begin
            if (in8) begin
                prdata = apb_data_t'(vram8_q);
            end else begin
                prdata = vram32_q;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                // Setup cycle
                if (psel && !penable) begin
                    next_state = st_access;
                end
            end
            st_access: begin
                if (rd_hit) begin
                    next_state = st_read_wait;
                end else begin
                    next_state = st_idle;
                end
            end
            st_read_wait: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

// File: hdl/vram_top.sv
// Video memory subsystem with APB access, tile and character memories and GPU activity LED
`timescale 1ns/1ps

module vram_top (
    input  logic                   clk,
    input  logic                   reset,

    // APB slave
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  vram_pkg::apb_addr_t    paddr,
    input  vram_pkg::apb_data_t    pwdata,
    output logic                   pready,
    output vram_pkg::apb_data_t    prdata,
    output logic                   pslverr,

    // Graphics engine read ports
    input  vram_pkg::vram32_addr_t gpu32_addr,
    output vram_pkg::vram32_word_t gpu32_q,
    input  vram_pkg::vram8_addr_t  gpu8_addr,
    output vram_pkg::vram8_word_t  gpu8_q,

    // Status
    output logic                   led_gpu
);

    import vram_pkg::*;

    // CPU ports of the memories
    vram32_addr_t vram32_addr;
    vram32_word_t vram32_d;
    logic         vram32_we;
    vram32_word_t vram32_q;

    vram8_addr_t  vram8_addr;
    vram8_word_t  vram8_d;
    logic         vram8_we;
    vram8_word_t  vram8_q;

    logic         write_strobe;

    apb_vram_fsm apb_vram_fsm0 (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .prdata       (prdata),
        .vram32_addr  (vram32_addr),
        .vram32_d     (vram32_d),
        .vram32_we    (vram32_we),
        .vram32_q     (vram32_q),
        .vram8_addr   (vram8_addr),
        .vram8_d      (vram8_d),
        .vram8_we     (vram8_we),
        .vram8_q      (vram8_q),
        .write_strobe (write_strobe)
    );

    // Tile and pattern memory
    vram_dp #(
        .WIDTH (32),
        .WORDS (VRAM32_WORDS)
    ) vram32 (
        .clk      (clk),
        .cpu_addr (vram32_addr),
        .cpu_d    (vram32_d),
        .cpu_we   (vram32_we),
        .cpu_q    (vram32_q),
        .gpu_addr (gpu32_addr),
        .gpu_q    (gpu32_q)
    );

    // Character memory
    vram_dp #(
        .WIDTH (8),
        .WORDS (VRAM8_WORDS)
    ) vram8 (
        .clk      (clk),
        .cpu_addr (vram8_addr),
        .cpu_d    (vram8_d),
        .cpu_we   (vram8_we),
        .cpu_q    (vram8_q),
        .gpu_addr (gpu8_addr),
        .gpu_q    (gpu8_q)
    );

    led_visualizer led_vis_gpu (
        .clk          (clk),
        .reset        (reset),
        .write_strobe (write_strobe),
        .led          (led_gpu)
    );

endmodule

// File: testbench/vram_top_properties.sv
// Concurrent checks on the APB slave handshake and the GPU activity LED
`timescale 1ns/1ps

module vram_top_properties (
    input logic                clk,
    input logic                reset,
    input logic                psel,
    input logic                penable,
    input logic                pwrite,
    input vram_pkg::apb_addr_t paddr,
    input logic                pready,
    input logic                pslverr,
    input logic                write_strobe,
    input logic                led_gpu
);

    import vram_pkg::*;

    logic rd_setup;

    // Setup cycle of a read that hits either memory
    assign rd_setup = psel && !penable && !pwrite &&
        ((paddr >= VRAM32_BASE && paddr < VRAM32_LIMIT) ||
         (paddr >= VRAM8_BASE && paddr < VRAM8_LIMIT));

    a_ready_in_access: assert property (@(posedge clk) disable iff (reset)
        pready |-> (psel && penable))
        else $error("pready outside an access cycle");

    a_error_with_ready: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> pready)
        else $error("pslverr without pready");

    // One wait state, then completion
    a_read_two_cycles: assert property (@(posedge clk) disable iff (reset)
        $past(rd_setup, 2) |-> (pready && !$past(pready)))
        else $error("in-range read did not complete two cycles after setup");

    a_strobe_lights_led: assert property (@(posedge clk) disable iff (reset)
        write_strobe |=> led_gpu)
        else $error("led_gpu not lit after a memory write");

endmodule

bind vram_top vram_top_properties props0 (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pready       (pready),
    .pslverr      (pslverr),
    .write_strobe (write_strobe),
    .led_gpu      (led_gpu)
);

// File: testbench/vram_top_tb.sv
// Testbench for the video memory subsystem covering APB access, GPU read ports and the activity LED
`timescale 1ns/1ps

module vram_top_tb;

    import vram_pkg::*;

    localparam int APB_TIMEOUT   = 8;
    localparam int DRAIN_TIMEOUT = 16;
    localparam int LED_TIMEOUT   = 4 * LED_MIN_CLK;
    localparam int NUM_WRITES    = 24;

    // One finished APB transfer as seen on the bus
    typedef struct packed {
        logic      is_write;
        apb_addr_t addr;
        apb_data_t wdata;
        apb_data_t rdata;
        logic      slverr;
        int        cycles;
    } xfer_t;

    logic         clk;
    logic         reset;
    logic         psel;
    logic         penable;
    logic         pwrite;
    apb_addr_t    paddr;
    apb_data_t    pwdata;
    logic         pready;
    apb_data_t    prdata;
    logic         pslverr;
    vram32_addr_t gpu32_addr;
    vram32_word_t gpu32_q;
    vram8_addr_t  gpu8_addr;
    vram8_word_t  gpu8_q;
    logic         led_gpu;

    // Shadow copies of both memories
    vram32_word_t shadow32 [VRAM32_WORDS];
    vram8_word_t  shadow8 [VRAM8_WORDS];
    int           written32 [$];
    int           written8 [$];

    xfer_t        xfers [$];
    int           gpu32_pend [$];
    int           gpu8_pend [$];

    integer       seed;
    int           apb_errors = 0;
    int           gpu_errors = 0;
    int           led_errors = 0;
    int           timeouts = 0;

    vram_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pready     (pready),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .gpu32_addr (gpu32_addr),
        .gpu32_q    (gpu32_q),
        .gpu8_addr  (gpu8_addr),
        .gpu8_q     (gpu8_q),
        .led_gpu    (led_gpu)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Hard limit on the whole run
    initial begin
        #500000;
        $display("Simulation did not finish within the time limit");
        $display("Testbench failed");
        $finish;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // Expected read data from the address map and the shadow memories
    function automatic apb_data_t expected_read(input apb_addr_t addr, output logic exp_err);
        int a;
        a = int'(addr);
        exp_err = 1'b0;
        if (a >= int'(VRAM32_BASE) && a < int'(VRAM32_BASE) + VRAM32_WORDS) begin
            return shadow32[a - int'(VRAM32_BASE)];
        end
        if (a >= int'(VRAM8_BASE) && a < int'(VRAM8_BASE) + VRAM8_WORDS) begin
            return {24'h0, shadow8[a - int'(VRAM8_BASE)]};
        end
        exp_err = 1'b1;
        return '0;
    endfunction

    // Character memory keeps only the low byte
    function automatic void store_shadow(input apb_addr_t addr, input apb_data_t data);
        int a;
        a = int'(addr);
        if (a < int'(VRAM32_BASE) + VRAM32_WORDS) begin
            shadow32[a - int'(VRAM32_BASE)] = data;
        end else begin
            shadow8[a - int'(VRAM8_BASE)] = data[7:0];
        end
    endfunction

    task automatic apb_transfer(input logic is_write, input apb_addr_t addr,
                                input apb_data_t data);
        xfer_t x;
        int    n;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        n = 1;
        #1;
        while (!pready && n < APB_TIMEOUT) begin
            @(negedge clk);
            n++;
            #1;
        end
        if (!pready) begin
            timeouts++;
            $display("Timeout: no pready after %0d access cycles at address 0x%04h", n, addr);
        end else begin
            x.is_write = is_write;
            x.addr     = addr;
            x.wdata    = data;
            x.rdata    = prdata;
            x.slverr   = pslverr;
            x.cycles   = n;
            xfers.push_back(x);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_back_all;
        int i;
        for (i = 0; i < written32.size(); i++) begin
            apb_transfer(1'b0, apb_addr_t'(int'(VRAM32_BASE) + written32[i]), '0);
        end
        for (i = 0; i < written8.size(); i++) begin
            apb_transfer(1'b0, apb_addr_t'(int'(VRAM8_BASE) + written8[i]), '0);
        end
    endtask

    task automatic out_of_range_pair(input int addr);
        apb_transfer(1'b1, apb_addr_t'(addr), apb_data_t'($random(seed)));
        apb_transfer(1'b0, apb_addr_t'(addr), '0);
    endtask

    task automatic wait_drained;
        int n;
        n = 0;
        while ((xfers.size() > 0 || gpu32_pend.size() > 0) && n < DRAIN_TIMEOUT) begin
            @(negedge clk);
            #2;
            n++;
        end
        if (xfers.size() > 0 || gpu32_pend.size() > 0) begin
            timeouts++;
            $display("Timeout: the compare process did not catch up with the bus");
        end
    endtask

    // New GPU addresses every cycle, several reads in flight
    task automatic gpu_sweep(input int count);
        int i;
        int a32;
        int a8;
        for (i = 0; i < count; i++) begin
            @(negedge clk);
            a32 = written32[rand_below(written32.size())];
            a8  = written8[rand_below(written8.size())];
            gpu32_addr = vram32_addr_t'(a32);
            gpu8_addr  = vram8_addr_t'(a8);
            #1;
            gpu32_pend.push_back(a32);
            gpu8_pend.push_back(a8);
        end
    endtask

    task automatic check_led_low(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            #1;
            assert (!led_gpu) else begin
                led_errors++;
                $display("ERR %0t: led_gpu is lit without an in-range write", $time);
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_led_off;
        int n;
        n = 0;
        #1;
        while (led_gpu && n < LED_TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (led_gpu) begin
            timeouts++;
            $display("Timeout: led_gpu did not go dark after the last write");
        end
    endtask

    // Called at the falling edge right after a write completes
    task automatic check_led_stretch;
        int n;
        n = 0;
        #1;
        while (led_gpu && n <= LED_MIN_CLK + 4) begin
            n++;
            @(negedge clk);
            #1;
        end
        assert (n == LED_MIN_CLK) else begin
            led_errors++;
            $display("ERR %0t: led_gpu stayed lit %0d cycles, expected %0d",
                     $time, n, LED_MIN_CLK);
        end
    endtask

    initial begin : compare
        xfer_t     x;
        apb_data_t exp_data;
        logic      exp_err;
        int        exp_cycles;
        int        a32;
        int        a8;

        forever begin
            @(negedge clk);
            while (xfers.size() > 0) begin
                x = xfers.pop_front();
                exp_data   = expected_read(x.addr, exp_err);
                exp_cycles = (x.is_write || exp_err) ? 1 : 2;
                assert (x.cycles == exp_cycles) else begin
                    apb_errors++;
                    $display("ERR %0t: transfer at 0x%04h took %0d access cycles, expected %0d",
                             $time, x.addr, x.cycles, exp_cycles);
                end
                assert (x.slverr == exp_err) else begin
                    apb_errors++;
                    $display("ERR %0t: pslverr %0b at 0x%04h, expected %0b",
                             $time, x.slverr, x.addr, exp_err);
                end
                if (!x.is_write || exp_err) begin
                    assert (x.rdata == exp_data) else begin
                        apb_errors++;
                        $display("ERR %0t: prdata 0x%08h at 0x%04h, expected 0x%08h",
                                 $time, x.rdata, x.addr, exp_data);
                    end
                end
                if (x.is_write && !exp_err) begin
                    store_shadow(x.addr, x.wdata);
                end
            end
            if (gpu32_pend.size() > 0) begin
                a32 = gpu32_pend.pop_front();
                a8  = gpu8_pend.pop_front();
                assert (gpu32_q == shadow32[a32]) else begin
                    gpu_errors++;
                    $display("ERR %0t: gpu32_q 0x%08h at %0d, expected 0x%08h",
                             $time, gpu32_q, a32, shadow32[a32]);
                end
                assert (gpu8_q == shadow8[a8]) else begin
                    gpu_errors++;
                    $display("ERR %0t: gpu8_q 0x%02h at %0d, expected 0x%02h",
                             $time, gpu8_q, a8, shadow8[a8]);
                end
            end
        end
    end

    initial begin : stimulus
        int i;
        int a;
        int total;

        seed       = 16;
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        gpu32_addr = '0;
        gpu8_addr  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_led_low(3);

        // Edges of both memories, then random words
        written32.push_back(VRAM32_WORDS - 1);
        written8.push_back(0);
        written8.push_back(VRAM8_WORDS - 1);
        apb_transfer(1'b1, apb_addr_t'(int'(VRAM32_BASE) + VRAM32_WORDS - 1), 32'hcafe_f00d);
        apb_transfer(1'b1, VRAM8_BASE, 32'h1234_56a5);
        apb_transfer(1'b1, apb_addr_t'(int'(VRAM8_BASE) + VRAM8_WORDS - 1), 32'hffff_ff3c);
        for (i = 0; i < NUM_WRITES; i++) begin
            a = rand_below(VRAM32_WORDS);
            written32.push_back(a);
            apb_transfer(1'b1, apb_addr_t'(int'(VRAM32_BASE) + a), apb_data_t'($random(seed)));
            a = rand_below(VRAM8_WORDS);
            written8.push_back(a);
            apb_transfer(1'b1, apb_addr_t'(int'(VRAM8_BASE) + a), apb_data_t'($random(seed)));
        end
        read_back_all();

        // Gap between the memories and the space above the character memory
        out_of_range_pair(int'(VRAM32_BASE) + VRAM32_WORDS);
        out_of_range_pair(int'(VRAM8_BASE) - 1);
        out_of_range_pair(int'(VRAM8_BASE) + VRAM8_WORDS);
        out_of_range_pair(16'hffff);
        for (i = 0; i < 6; i++) begin
            a = int'(VRAM32_BASE) + VRAM32_WORDS;
            out_of_range_pair(a + rand_below(int'(VRAM8_BASE) - a));
            a = int'(VRAM8_BASE) + VRAM8_WORDS;
            out_of_range_pair(a + rand_below(65536 - a));
        end
        read_back_all();
        wait_drained();

        gpu_sweep(64);
        wait_drained();

        // Activity LED
        wait_led_off();
        apb_transfer(1'b0, apb_addr_t'(int'(VRAM32_BASE) + written32[0]), '0);
        check_led_low(3);
        apb_transfer(1'b1, 16'h8000, 32'h0bad_0bad);
        check_led_low(3);
        apb_transfer(1'b1, apb_addr_t'(int'(VRAM8_BASE) + written8[1]), 32'h0000_0077);
        check_led_stretch();
        apb_transfer(1'b1, apb_addr_t'(int'(VRAM32_BASE) + written32[1]), 32'h5a5a_a5a5);
        repeat (5) @(negedge clk);
        apb_transfer(1'b1, apb_addr_t'(int'(VRAM32_BASE) + written32[2]), 32'h0f0f_f0f0);
        check_led_stretch();
        read_back_all();
        wait_drained();

        total = apb_errors + gpu_errors + led_errors + timeouts;
        $display("Errors: apb %0d, gpu %0d, led %0d, timeouts %0d",
                 apb_errors, gpu_errors, led_errors, timeouts);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: vram_top.f
hdl/vram_pkg.sv
hdl/vram_dp.sv
hdl/led_visualizer.sv
hdl/apb_vram_fsm.sv
hdl/vram_top.sv
testbench/vram_top_properties.sv
testbench/vram_top_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the video memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module vram_top_tb -f vram_top.f -o vram_top_sim \
    && ./obj_dir/vram_top_sim | tee /dev/stderr | grep -q "Testbench passed" \
    && echo "Simulation run: PASS" \
    || { echo "Simulation run: FAIL"; exit 1; }
